/* hw/videoPkg.sv */
/*
 * Shared types and APB register map of the video transmit subsystem.
 * Addresses are byte offsets on an 8-bit APB address; only aligned words decode.
 */
package videoPkg;

	// --------------------
	// Pixel and raster types
	// --------------------

	// RGB565, red in 15:11, green in 10:5, blue in 4:0
	typedef logic [15:0] pixelT;

	// One horizontal or vertical coordinate
	typedef logic [9:0] coordT;

	// Solid rectangle with inclusive bounds
	typedef struct packed {
		pixelT color;
		coordT left;
		coordT right;
		coordT top;
		coordT under;
	} rectT;

	// --------------------
	// APB types
	// --------------------

	typedef logic [7:0] apbAddrT;
	typedef logic [31:0] apbDataT;

	typedef struct packed {
		logic sel;
		logic enable;
		logic write;
		apbAddrT addr;
		apbDataT wdata;
	} apbReqT;

	typedef struct packed {
		apbDataT rdata;
		logic ready;
		logic slvErr;
	} apbRspT;

	// Register offsets
	localparam apbAddrT cRegCtrl = 8'h00;
	localparam apbAddrT cRegBg = 8'h04;
	// Rectangle n at base + 16n, words for colour, left/right, top/under
	localparam apbAddrT cRegRectBase = 8'h10;

	// Default FIFO depth, as log2
	localparam int cFifoDepthLog = 6;

endpackage

/* hw/videoCsrApb.sv */
/*
 * Zero wait state APB register file, all registers reset to zero.
 * At most 15 rectangles fit in the 8-bit address map.
 */
`timescale 1ns/1ps

module videoCsrApb #(
	parameter int pRectCount = 4
)(
	input logic iVCLK,
	input logic iVRST,
	input videoPkg::apbReqT apbReq,
	output videoPkg::apbRspT apbRsp,
	output logic videoEn,
	output videoPkg::pixelT bgColor,
	output videoPkg::rectT rects [pRectCount]
);

	// --------------------
	// Address decode
	// --------------------
	videoPkg::apbAddrT rectOff;
	logic [3:0] rectIdx;
	logic [1:0] rectWord;
	logic aligned;
	logic ctrlHit;
	logic bgHit;
	logic rectHit;
	logic addrHit;
	logic wrAcc;
	videoPkg::rectT selRect;
	videoPkg::apbDataT rdData;

	assign rectOff = apbReq.addr - videoPkg::cRegRectBase;
	assign rectIdx = rectOff[7:4];
	assign rectWord = rectOff[3:2];
	assign aligned = (apbReq.addr[1:0] == 2'b00);

	assign ctrlHit = aligned && (apbReq.addr == videoPkg::cRegCtrl);
	assign bgHit = aligned && (apbReq.addr == videoPkg::cRegBg);
	// Fourth word of each rectangle slot is a hole
	assign rectHit = aligned && (apbReq.addr >= videoPkg::cRegRectBase)
		&& (int'(rectIdx) < pRectCount) && (rectWord != 2'd3);
	assign addrHit = ctrlHit || bgHit || rectHit;

	assign wrAcc = apbReq.sel && apbReq.enable && apbReq.write && addrHit;

	// Rectangle selected by the address
	always_comb
	begin
		selRect = '0;
		for (int n = 0; n < pRectCount; n++)
		begin
			if (rectIdx == 4'(n))
				selRect = rects[n];
		end
	end

	// --------------------
	// Read path
	// --------------------
	always_comb
	begin
		rdData = '0;
		if (ctrlHit)
			rdData = {31'b0, videoEn};
		else if (bgHit)
			rdData = {16'b0, bgColor};
		else if (rectHit)
		begin
			case (rectWord)
				2'd0: rdData = {16'b0, selRect.color};
				2'd1: rdData = {6'b0, selRect.right, 6'b0, selRect.left};
				default: rdData = {6'b0, selRect.under, 6'b0, selRect.top};
			endcase
		end
	end

	assign apbRsp.rdata = rdData;
	assign apbRsp.ready = 1'b1;
	assign apbRsp.slvErr = apbReq.sel && apbReq.enable && !addrHit;

	// --------------------
	// Write path
	// --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST)
		begin
			videoEn <= 1'b0;
			bgColor <= '0;
			for (int n = 0; n < pRectCount; n++)
			begin
				rects[n] <= '0;
			end
		end
		else if (wrAcc)
		begin
			if (ctrlHit)
				videoEn <= apbReq.wdata[0];
			if (bgHit)
				bgColor <= apbReq.wdata[15:0];
			for (int n = 0; n < pRectCount; n++)
			begin
				if (rectHit && rectIdx == 4'(n))
				begin
					case (rectWord)
						2'd0: rects[n].color <= apbReq.wdata[15:0];
						2'd1:
						begin
							rects[n].left <= apbReq.wdata[9:0];
							rects[n].right <= apbReq.wdata[25:16];
						end
						default:
						begin
							rects[n].top <= apbReq.wdata[9:0];
							rects[n].under <= apbReq.wdata[25:16];
						end
					endcase
				end
			end
		end
	end

endmodule

/* hw/rectPixelGen.sv */
/*
 * Raster order pixel source, one pixel per cycle while the FIFO has room.
 * Rectangle set and background are sampled once per frame at pixel (0,0).
 */
`timescale 1ns/1ps

module rectPixelGen #(
	parameter int pRectCount = 4,
	parameter int pHActive = 480,
	parameter int pVActive = 272
)(
	input logic iVCLK,
	input logic iVRST,
	input logic videoEn,
	input videoPkg::pixelT bgColor,
	input videoPkg::rectT rects [pRectCount],
	input logic full,
	output videoPkg::pixelT wrData,
	output logic wrEn
);

	videoPkg::coordT xPos;
	videoPkg::coordT yPos;
	logic frameStart;
	logic lineEnd;
	logic frameEnd;

	// Frame snapshot of the configuration
	videoPkg::rectT rectLatch [pRectCount];
	videoPkg::pixelT bgLatch;
	videoPkg::rectT selRects [pRectCount];
	videoPkg::pixelT selBg;
	logic [pRectCount-1:0] rectHit;

	assign frameStart = (xPos == '0) && (yPos == '0);
	assign lineEnd = (xPos == videoPkg::coordT'(pHActive - 1));
	assign frameEnd = lineEnd && (yPos == videoPkg::coordT'(pVActive - 1));

	assign wrEn = videoEn && !full;

	// --------------------
	// Raster position
	// --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !videoEn)
		begin
			xPos <= '0;
			yPos <= '0;
		end
		else if (wrEn)
		begin
			if (frameEnd)
			begin
				xPos <= '0;
				yPos <= '0;
			end
			else if (lineEnd)
			begin
				xPos <= '0;
				yPos <= yPos + 1'b1;
			end
			else
				xPos <= xPos + 1'b1;
		end
	end

	// Snapshot taken as the first pixel is written
	always_ff @(posedge iVCLK)
	begin
		if (wrEn && frameStart)
		begin
			bgLatch <= bgColor;
			rectLatch <= rects;
		end
	end

	// First pixel sees the live registers, the rest the snapshot
	always_comb
	begin
		selBg = frameStart ? bgColor : bgLatch;
		for (int n = 0; n < pRectCount; n++)
		begin
			selRects[n] = frameStart ? rects[n] : rectLatch[n];
		end
	end

	// --------------------
	// Colour selection
	// --------------------
	always_comb
	begin
		for (int n = 0; n < pRectCount; n++)
		begin
			rectHit[n] = (xPos >= selRects[n].left) && (xPos <= selRects[n].right)
				&& (yPos >= selRects[n].top) && (yPos <= selRects[n].under);
		end
	end

	// Walk from the highest index so the lowest covering rectangle wins
	always_comb
	begin
		wrData = selBg;
		for (int n = pRectCount - 1; n >= 0; n--)
		begin
			if (rectHit[n])
				wrData = selRects[n].color;
		end
	end

endmodule

/* hw/pixelFifo.sv */
/*
 * Single clock pixel FIFO, head entry shown combinationally on rdData.
 * Writes when full and reads when empty are dropped.
 */
`timescale 1ns/1ps

module pixelFifo #(
	parameter int pFifoDepthLog = 6
)(
	input logic iVCLK,
	input logic iVRST,
	input logic videoEn,
	input videoPkg::pixelT wrData,
	input logic wrEn,
	input logic rdEn,
	output videoPkg::pixelT rdData,
	output logic full,
	output logic empty
);

	videoPkg::pixelT mem [2**pFifoDepthLog];
	logic [pFifoDepthLog-1:0] wrPtr;
	logic [pFifoDepthLog-1:0] rdPtr;
	logic [pFifoDepthLog:0] count;
	logic doWr;
	logic doRd;

	assign doWr = wrEn && !full;
	assign doRd = rdEn && !empty;

	// Count never exceeds the depth, so the top bit alone means full
	assign full = count[pFifoDepthLog];
	assign empty = (count == '0);
	assign rdData = mem[rdPtr];

	always_ff @(posedge iVCLK)
	begin
		if (doWr)
			mem[wrPtr] <= wrData;
	end

	// Pointers and occupancy, flushed while video is off
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !videoEn)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
			count <= '0;
		end
		else
		begin
			if (doWr)
				wrPtr <= wrPtr + 1'b1;
			if (doRd)
				rdPtr <= rdPtr + 1'b1;
			case ({doWr, doRd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

endmodule

/* hw/videoTimingGen.sv */
/*
 * Panel timing: sync, back porch, active, front porch on both axes.
 * HS, VS and DE are active high; outputs lag the counters by one cycle.
 */
`timescale 1ns/1ps

module videoTimingGen #(
	parameter int pHActive = 480,
	parameter int pHFront = 8,
	parameter int pHSync = 10,
	parameter int pHBack = 43,
	parameter int pVActive = 272,
	parameter int pVFront = 12,
	parameter int pVSync = 10,
	parameter int pVBack = 4
)(
	input logic iVCLK,
	input logic iVRST,
	input logic videoEn,
	input videoPkg::pixelT rdData,
	input logic full,
	output logic rdEn,
	output logic [7:0] videoR,
	output logic [7:0] videoG,
	output logic [7:0] videoB,
	output logic videoHs,
	output logic videoVs,
	output logic videoDe
);

	localparam int cHActStart = pHSync + pHBack;
	localparam int cHActEnd = cHActStart + pHActive;
	localparam int cHTotal = cHActEnd + pHFront;
	localparam int cVActStart = pVSync + pVBack;
	localparam int cVActEnd = cVActStart + pVActive;
	localparam int cVTotal = cVActEnd + pVFront;
	localparam int cHW = $clog2(cHTotal);
	localparam int cVW = $clog2(cVTotal);

	typedef enum logic {stWait, stRun} stateT;

	stateT state;
	logic [cHW-1:0] hCnt;
	logic [cVW-1:0] vCnt;
	logic hLast;
	logic vLast;
	logic hAct;
	logic vAct;
	logic pixActive;

	assign hLast = (hCnt == cHW'(cHTotal - 1));
	assign vLast = (vCnt == cVW'(cVTotal - 1));
	assign hAct = (hCnt >= cHW'(cHActStart)) && (hCnt < cHW'(cHActEnd));
	assign vAct = (vCnt >= cVW'(cVActStart)) && (vCnt < cVW'(cVActEnd));
	assign pixActive = (state == stRun) && hAct && vAct;

	// Pop in the same cycle the pixel is registered out
	assign rdEn = pixActive;

	// --------------------
	// FSM and counters
	// --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !videoEn)
		begin
			state <= stWait;
			hCnt <= '0;
			vCnt <= '0;
		end
		else
		begin
			case (state)
				stWait:
				begin
					// Prime the FIFO before the first frame
					if (full)
						state <= stRun;
				end
				stRun:
				begin
					if (hLast)
					begin
						hCnt <= '0;
						vCnt <= vLast ? '0 : vCnt + 1'b1;
					end
					else
						hCnt <= hCnt + 1'b1;
				end
				default: state <= stWait;
			endcase
		end
	end

	// --------------------
	// Output stage
	// --------------------
	always_ff @(posedge iVCLK)
	begin
		if (iVRST || !videoEn)
		begin
			videoHs <= 1'b0;
			videoVs <= 1'b0;
			videoDe <= 1'b0;
			videoR <= '0;
			videoG <= '0;
			videoB <= '0;
		end
		else
		begin
			videoHs <= (state == stRun) && (hCnt < cHW'(pHSync));
			videoVs <= (state == stRun) && (vCnt < cVW'(pVSync));
			videoDe <= pixActive;
			// RGB565 to 8 bits, low bits zero
			videoR <= pixActive ? {rdData[15:11], 3'b000} : 8'd0;
			videoG <= pixActive ? {rdData[10:5], 2'b00} : 8'd0;
			videoB <= pixActive ? {rdData[4:0], 3'b000} : 8'd0;
		end
	end

endmodule

/* hw/videoTxTop.sv */
/*
 * Video transmit subsystem, single clock, APB configured.
 * Raster sizes and FIFO depth are fixed at elaboration.
 */
`timescale 1ns/1ps

module videoTxTop #(
	parameter int pRectCount = 4,
	parameter int pHActive = 480,
	parameter int pHFront = 8,
	parameter int pHSync = 10,
	parameter int pHBack = 43,
	parameter int pVActive = 272,
	parameter int pVFront = 12,
	parameter int pVSync = 10,
	parameter int pVBack = 4,
	parameter int pFifoDepthLog = videoPkg::cFifoDepthLog
)(
	input logic iVCLK,
	input logic iVRST,
	input videoPkg::apbReqT apbReq,
	output videoPkg::apbRspT apbRsp,
	output logic [7:0] videoR,
	output logic [7:0] videoG,
	output logic [7:0] videoB,
	output logic videoHs,
	output logic videoVs,
	output logic videoDe
);

	logic videoEn;
	videoPkg::pixelT bgColor;
	videoPkg::rectT rects [pRectCount];
	videoPkg::pixelT wrData;
	logic wrEn;
	logic full;
	videoPkg::pixelT rdData;
	logic rdEn;

	// --------------------
	// Configuration
	// --------------------
	videoCsrApb #(.pRectCount(pRectCount)) videoCsrApb_inst (
		.iVCLK(iVCLK), .iVRST(iVRST),
		.apbReq(apbReq), .apbRsp(apbRsp),
		.videoEn(videoEn), .bgColor(bgColor), .rects(rects)
	);

	// --------------------
	// Pixel pipeline
	// --------------------
	rectPixelGen #(
		.pRectCount(pRectCount), .pHActive(pHActive), .pVActive(pVActive)
	) rectPixelGen_inst (
		.iVCLK(iVCLK), .iVRST(iVRST), .videoEn(videoEn),
		.bgColor(bgColor), .rects(rects), .full(full),
		.wrData(wrData), .wrEn(wrEn)
	);

	pixelFifo #(.pFifoDepthLog(pFifoDepthLog)) pixelFifo_inst (
		.iVCLK(iVCLK), .iVRST(iVRST), .videoEn(videoEn),
		.wrData(wrData), .wrEn(wrEn), .rdEn(rdEn),
		.rdData(rdData), .full(full), .empty()
	);

	videoTimingGen #(
		.pHActive(pHActive), .pHFront(pHFront), .pHSync(pHSync), .pHBack(pHBack),
		.pVActive(pVActive), .pVFront(pVFront), .pVSync(pVSync), .pVBack(pVBack)
	) videoTimingGen_inst (
		.iVCLK(iVCLK), .iVRST(iVRST), .videoEn(videoEn),
		.rdData(rdData), .full(full), .rdEn(rdEn),
		.videoR(videoR), .videoG(videoG), .videoB(videoB),
		.videoHs(videoHs), .videoVs(videoVs), .videoDe(videoDe)
	);

endmodule

/* include/videoTxTbTasks.svh */
/*
 * Register map model, raster colour rule and compare tasks.
 * Included inside videoTxTb and uses its cRectCount and cHActive.
 */
`ifndef VIDEO_TX_TB_TASKS_SVH
`define VIDEO_TX_TB_TASKS_SVH

// Shadow copy of the register file
logic shadowEn;
videoPkg::pixelT shadowBg;
videoPkg::rectT shadowRects [cRectCount];

// --------------------
// Register map model
// --------------------

// Mapped word i: control, background, then three words per rectangle
function automatic videoPkg::apbAddrT regAddr(input int i);
	if (i == 0)
		return videoPkg::cRegCtrl;
	if (i == 1)
		return videoPkg::cRegBg;
	return videoPkg::apbAddrT'(int'(videoPkg::cRegRectBase) + 16 * ((i - 2) / 3)
		+ 4 * ((i - 2) % 3));
endfunction

function automatic void shadowWrite(input videoPkg::apbAddrT addr,
	input videoPkg::apbDataT data);
	int n;
	int w;
	n = (int'(addr) - int'(videoPkg::cRegRectBase)) / 16;
	w = (int'(addr) / 4) % 4;
	if (addr == videoPkg::cRegCtrl)
		shadowEn = data[0];
	else if (addr == videoPkg::cRegBg)
		shadowBg = data[15:0];
	else if (w == 0)
		shadowRects[n].color = data[15:0];
	else if (w == 1)
	begin
		shadowRects[n].left = data[9:0];
		shadowRects[n].right = data[25:16];
	end
	else
	begin
		shadowRects[n].top = data[9:0];
		shadowRects[n].under = data[25:16];
	end
endfunction

// Read value, unimplemented bits as zero
function automatic videoPkg::apbDataT expectedRead(input videoPkg::apbAddrT addr);
	int n;
	int w;
	n = (int'(addr) - int'(videoPkg::cRegRectBase)) / 16;
	w = (int'(addr) / 4) % 4;
	if (addr == videoPkg::cRegCtrl)
		return {31'b0, shadowEn};
	if (addr == videoPkg::cRegBg)
		return {16'b0, shadowBg};
	if (w == 0)
		return {16'b0, shadowRects[n].color};
	if (w == 1)
		return {6'b0, shadowRects[n].right, 6'b0, shadowRects[n].left};
	return {6'b0, shadowRects[n].under, 6'b0, shadowRects[n].top};
endfunction

// Lowest-numbered covering rectangle wins, else background
function automatic videoPkg::pixelT expectedPixel(input int x, input int y);
	for (int n = 0; n < cRectCount; n++)
	begin
		if (x >= int'(shadowRects[n].left) && x <= int'(shadowRects[n].right)
			&& y >= int'(shadowRects[n].top) && y <= int'(shadowRects[n].under))
			return shadowRects[n].color;
	end
	return shadowBg;
endfunction

// --------------------
// Compare tasks
// --------------------
task automatic checkPixel(input int idx, input videoPkg::pixelT expPix,
	input logic [23:0] gotRgb);
	logic [23:0] expRgb;
	// Zero fill of each channel to 8 bits
	expRgb = {expPix[15:11], 3'b000, expPix[10:5], 2'b00, expPix[4:0], 3'b000};
	if (gotRgb !== expRgb)
	begin
		$display("Error videoR/G/B at x %0d y %0d: got %h expected %h",
			idx % cHActive, (idx / cHActive) % cVActive, gotRgb, expRgb);
		$display("Something failed");
		$fatal(1, "pixel colour mismatch");
	end
endtask

task automatic checkApbData(input videoPkg::apbAddrT addr, input videoPkg::apbDataT got,
	input videoPkg::apbDataT expVal);
	if (got !== expVal)
	begin
		$display("Error apbRsp.rdata at addr %h: got %h expected %h", addr, got, expVal);
		$display("Something failed");
		$fatal(1, "read data mismatch");
	end
endtask

task automatic checkFlag(input string name, input logic got, input logic expVal);
	if (got !== expVal)
	begin
		$display("Error %s: got %h expected %h", name, got, expVal);
		$display("Something failed");
		$fatal(1, "flag mismatch");
	end
endtask

task automatic checkCount(input string name, input int got, input int expVal);
	if (got != expVal)
	begin
		$display("Error %s: got %h expected %h", name, got, expVal);
		$display("Something failed");
		$fatal(1, "timing mismatch");
	end
endtask

`endif

/* testbench/videoTxTb.sv */
/*
 * Testbench for videoTxTop on a 24 x 12 raster with four rectangles.
 * Random stimulus from a fixed seed; the run stops at the first mismatch.
 */
`timescale 1ns/1ps

module videoTxTb;

	localparam int cRectCount = 4;
	localparam int cHActive = 24;
	localparam int cHFront = 2;
	localparam int cHSync = 2;
	localparam int cHBack = 3;
	localparam int cVActive = 12;
	localparam int cVFront = 2;
	localparam int cVSync = 2;
	localparam int cVBack = 3;
	localparam int cLineLen = cHSync + cHBack + cHActive + cHFront;
	localparam int cFrameLen = cLineLen * (cVSync + cVBack + cVActive + cVFront);
	localparam int cMappedRegs = 2 + 3 * cRectCount;
	localparam int cScenarios = 3;
	localparam int cFrames = 2;
	// Two spare frames per scenario for FIFO fill, APB traffic and the idle check
	localparam int cTimeoutNs = (cScenarios * (cFrames + 2) * cFrameLen + 4000) * 4;

	logic iVCLK;
	logic iVRST;
	videoPkg::apbReqT apbReq;
	videoPkg::apbRspT apbRsp;
	logic [7:0] videoR;
	logic [7:0] videoG;
	logic [7:0] videoB;
	logic videoHs;
	logic videoVs;
	logic videoDe;

	// Monitor state
	logic monOn;
	logic [23:0] pixQ [$];
	int cycle;
	int deRun;
	int deLines;
	int hsRun;
	int hsRise;
	int vsRun;
	logic hsSeen;
	logic vsSeen;
	logic prevDe;
	logic prevHs;
	logic prevVs;

	`include "videoTxTbTasks.svh"

	videoTxTop #(
		.pRectCount(cRectCount), .pHActive(cHActive), .pHFront(cHFront),
		.pHSync(cHSync), .pHBack(cHBack), .pVActive(cVActive), .pVFront(cVFront),
		.pVSync(cVSync), .pVBack(cVBack), .pFifoDepthLog(videoPkg::cFifoDepthLog)
	) videoTxTop_inst (
		.iVCLK(iVCLK), .iVRST(iVRST), .apbReq(apbReq), .apbRsp(apbRsp),
		.videoR(videoR), .videoG(videoG), .videoB(videoB),
		.videoHs(videoHs), .videoVs(videoVs), .videoDe(videoDe)
	);

	initial
	begin
		iVCLK = 1'b0;
		forever #2 iVCLK = ~iVCLK;
	end

	initial
	begin
		#(cTimeoutNs);
		$display("Something failed");
		$fatal(1, "Timeout: the tests did not finish in the expected time");
	end

	// --------------------
	// Output monitor
	// --------------------
	always @(negedge iVCLK)
	begin
		if (!monOn)
		begin
			pixQ.delete();
			cycle = 0;
			deRun = 0;
			deLines = 0;
			hsRun = 0;
			vsRun = 0;
			hsSeen = 1'b0;
			vsSeen = 1'b0;
			prevDe = 1'b0;
			prevHs = 1'b0;
			prevVs = 1'b0;
		end
		else
		begin
			cycle++;
			if (videoDe)
			begin
				pixQ.push_back({videoR, videoG, videoB});
				deRun++;
			end
			if (videoDe && !prevDe)
				deLines++;
			if (!videoDe && prevDe)
			begin
				checkCount("videoDe high width", deRun, cHActive);
				deRun = 0;
			end
			if (videoHs)
				hsRun++;
			if (!videoHs && prevHs)
			begin
				checkCount("videoHs high width", hsRun, cHSync);
				hsRun = 0;
			end
			if (videoHs && !prevHs)
			begin
				if (hsSeen)
					checkCount("videoHs period", cycle - hsRise, cLineLen);
				hsSeen = 1'b1;
				hsRise = cycle;
			end
			if (videoVs)
				vsRun++;
			if (!videoVs && prevVs)
			begin
				checkCount("videoVs high width", vsRun, cVSync * cLineLen);
				vsRun = 0;
			end
			// Frame boundary, previous frame must have had every active line
			if (videoVs && !prevVs)
			begin
				if (vsSeen)
					checkCount("videoDe lines per frame", deLines, cVActive);
				vsSeen = 1'b1;
				deLines = 0;
			end
			prevDe = videoDe;
			prevHs = videoHs;
			prevVs = videoVs;
		end
	end

	// --------------------
	// APB driver
	// --------------------
	task automatic apbAccess(input logic wr, input videoPkg::apbAddrT addr,
		input videoPkg::apbDataT wdata, output videoPkg::apbDataT rdata, output logic err);
		@(posedge iVCLK);
		apbReq <= '{sel: 1'b1, enable: 1'b0, write: wr, addr: addr, wdata: wdata};
		@(posedge iVCLK);
		apbReq.enable <= 1'b1;
		@(negedge iVCLK);
		checkFlag("apbRsp.ready", apbRsp.ready, 1'b1);
		rdata = apbRsp.rdata;
		err = apbRsp.slvErr;
		@(posedge iVCLK);
		apbReq <= '0;
	endtask

	task automatic writeReg(input videoPkg::apbAddrT addr, input videoPkg::apbDataT data);
		videoPkg::apbDataT rdata;
		logic err;
		apbAccess(1'b1, addr, data, rdata, err);
		checkFlag("apbRsp.slvErr", err, 1'b0);
		shadowWrite(addr, data);
	endtask

	task automatic readCheck(input videoPkg::apbAddrT addr);
		videoPkg::apbDataT rdata;
		logic err;
		apbAccess(1'b0, addr, '0, rdata, err);
		checkFlag("apbRsp.slvErr", err, 1'b0);
		checkApbData(addr, rdata, expectedRead(addr));
	endtask

	task automatic registerTest();
		videoPkg::apbAddrT badAddr [8];
		videoPkg::apbDataT rdata;
		logic err;
		// Gaps, slot holes, a rectangle past the count, unaligned, high space
		badAddr = '{8'h08, 8'h0C, 8'h1C, 8'h3C, 8'h50, 8'h12, 8'hC0, 8'hFC};
		for (int i = 0; i < cMappedRegs; i++)
			writeReg(regAddr(i), $urandom);
		for (int i = 0; i < cMappedRegs; i++)
			readCheck(regAddr(i));
		for (int i = 0; i < 8; i++)
		begin
			apbAccess(1'b1, badAddr[i], $urandom, rdata, err);
			checkFlag("apbRsp.slvErr", err, 1'b1);
			apbAccess(1'b0, badAddr[i], '0, rdata, err);
			checkFlag("apbRsp.slvErr", err, 1'b1);
			checkApbData(badAddr[i], rdata, '0);
		end
		for (int i = 0; i < cMappedRegs; i++)
			readCheck(regAddr(i));
		writeReg(videoPkg::cRegCtrl, '0);
	endtask

	// --------------------
	// Scenarios
	// --------------------
	function automatic videoPkg::rectT randomRect(input int kind);
		videoPkg::rectT r;
		int lo;
		r.color = videoPkg::pixelT'($urandom);
		case (kind)
			0:
			begin
				// Large boxes, any two share the middle of the screen
				r.left = videoPkg::coordT'($urandom_range(0, 10));
				r.right = videoPkg::coordT'($urandom_range(12, 23));
				r.top = videoPkg::coordT'($urandom_range(0, 5));
				r.under = videoPkg::coordT'($urandom_range(6, 11));
			end
			1:
			begin
				// Empty, left past right
				lo = $urandom_range(1, 23);
				r.left = videoPkg::coordT'(lo);
				r.right = videoPkg::coordT'($urandom_range(0, lo - 1));
				r.top = '0;
				r.under = videoPkg::coordT'(cVActive - 1);
			end
			default:
			begin
				// Runs off the right and bottom edges
				r.left = videoPkg::coordT'($urandom_range(12, 23));
				r.right = videoPkg::coordT'($urandom_range(24, 60));
				r.top = videoPkg::coordT'($urandom_range(6, 11));
				r.under = videoPkg::coordT'($urandom_range(12, 40));
			end
		endcase
		return r;
	endfunction

	task automatic loadRect(input int n, input videoPkg::rectT r);
		videoPkg::apbAddrT base;
		base = videoPkg::apbAddrT'(int'(videoPkg::cRegRectBase) + 16 * n);
		writeReg(base, {16'b0, r.color});
		writeReg(base + 8'd4, {6'b0, r.right, 6'b0, r.left});
		writeReg(base + 8'd8, {6'b0, r.under, 6'b0, r.top});
	endtask

	task automatic runScenario(input logic bgOnly);
		int nPix;
		nPix = cFrames * cHActive * cVActive;
		writeReg(videoPkg::cRegBg, $urandom);
		for (int n = 0; n < cRectCount; n++)
			loadRect(n, randomRect(bgOnly ? 1 : (n < 2 ? 0 : n - 1)));
		monOn = 1'b1;
		writeReg(videoPkg::cRegCtrl, 32'd1);
		while (pixQ.size() < nPix)
			@(posedge iVCLK);
		monOn = 1'b0;
		// Stream index 0 must be pixel (0,0) of the first frame
		for (int i = 0; i < nPix; i++)
			checkPixel(i, expectedPixel(i % cHActive, (i / cHActive) % cVActive), pixQ[i]);
		// Disable in the middle of an active line
		@(negedge iVCLK);
		while (!videoDe)
			@(negedge iVCLK);
		writeReg(videoPkg::cRegCtrl, '0);
		// Outputs drop one cycle after the enable bit, then stay low
		@(negedge iVCLK);
		repeat (cFrameLen)
		begin
			@(negedge iVCLK);
			checkFlag("videoDe", videoDe, 1'b0);
			checkFlag("videoHs", videoHs, 1'b0);
			checkFlag("videoVs", videoVs, 1'b0);
		end
	endtask

	initial
	begin
		void'($urandom(32'h23ad));
		iVRST = 1'b1;
		apbReq = '0;
		monOn = 1'b0;
		shadowEn = 1'b0;
		shadowBg = '0;
		for (int n = 0; n < cRectCount; n++)
			shadowRects[n] = '0;
		repeat (10) @(posedge iVCLK);
		iVRST <= 1'b0;
		registerTest();
		runScenario(1'b0);
		runScenario(1'b1);
		runScenario(1'b0);
		$display("Everything OK");
		$finish;
	end

endmodule

/* list.f */
+incdir+include
hw/videoPkg.sv
hw/videoCsrApb.sv
hw/rectPixelGen.sv
hw/pixelFifo.sv
hw/videoTimingGen.sv
hw/videoTxTop.sv
testbench/videoTxTb.sv

/* run.sh */
#!/bin/sh
# Build the Verilator model of the testbench and run it
# A failing check ends in $fatal, which gives a non-zero exit status
verilator --binary --timing -Wno-fatal --top-module videoTxTb -f list.f -o videoTxSim \
	&& ./obj_dir/videoTxSim \
	|| exit 1
